// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing -j 0
TOP      = tb_videoBackend
FILELIST = tb.f
OBJDIR   = obj_dir
BIN      = $(OBJDIR)/V$(TOP)
LOG      = sim.log
PASS_MSG = Testbench passed

SRCS = $(shell grep -v '^+' $(FILELIST))
HDRS = $(wildcard *.svh)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== lineBufBank.sv ====
`timescale 1ns/1ns
`include "videoBackend_macros.svh"

module lineBufBank (
	input logic CLK_1MB,
	input logic rstN,
	input videoBackendPkg::lbWrite_t wr,	// From spriteWriter
	input logic rdEn,	// Display read, clears the entry
	input logic [`LB_AW-1:0] rdAddr,
	output videoBackendPkg::sprPix_t rdData	// Valid the cycle after rdEn
);
	import videoBackendPkg::*;

	sprPix_t mem [`LB_DEPTH];
	logic clrBusy;	// Reset sweep running
	logic [`LB_AW-1:0] clrAddr;
	logic memWe;
	logic [`LB_AW-1:0] memAddr;
	sprPix_t memData;

	// Sweep starts once reset is released, one entry per cycle
	always_ff @(posedge CLK_1MB)
	begin
		if (!rstN)
		begin
			clrBusy <= 1'b1;
			clrAddr <= '0;
		end
		else if (clrBusy)
		begin
			clrAddr <= clrAddr + 1'b1;
			if (clrAddr == `LB_AW'(`LB_DEPTH - 1))
				clrBusy <= 1'b0;	// Last entry done
		end
	end

	// Single write port shared by sweep, clear-on-read and fill
	always_comb
	begin
		memWe = wr.we;
		memAddr = wr.addr;
		memData = wr.data;
		if (clrBusy)
		begin
			memWe = 1'b1;
			memAddr = clrAddr;
			memData = '0;
		end
		else if (rdEn)
		begin
			memWe = 1'b1;	// Zero behind the read
			memAddr = rdAddr;
			memData = '0;
		end
	end

	always_ff @(posedge CLK_1MB)
	begin
		if (memWe)
			mem[memAddr] <= memData;
		if (rdEn)
			rdData <= mem[rdAddr];	// Old value, before the clear
	end

endmodule

// ==== pixelMixer.sv ====
`timescale 1ns/1ns
`include "videoBackend_macros.svh"

module pixelMixer (
	input logic CLK_1MB,
	input logic rstN,
	input logic dispEn,	// One pixel out per cycle
	input logic lineStart,	// Rewind display counter
	input logic lineFlip,	// Display bank index
	input videoBackendPkg::fixPix_t fix,
	input logic blank,	// Forces PA to zero
	output logic [`NUM_BANKS-1:0] rdEn,
	output logic [`LB_AW-1:0] rdAddr,
	input videoBackendPkg::sprPix_t rdData [`NUM_BANKS],
	output logic [`PA_W-1:0] pa,	// Palette address
	output logic paValid
);
	import videoBackendPkg::*;

	logic [`LB_AW-1:0] dispCnt;
	logic [`LB_AW-1:0] curAddr;
	fixPix_t fixQ;	// Stage 1, aligned with RAM output
	logic blankQ;
	logic selQ;	// Bank that was read
	logic validQ;
	sprPix_t sprPix;
	logic fixOpaque;
	logic [`PA_W-1:0] paNext;

	// lineStart in the same cycle as dispEn reads pixel 0
	assign curAddr = lineStart ? '0 : dispCnt;
	assign rdAddr = curAddr;

	always_ff @(posedge CLK_1MB)
	begin
		if (!rstN)
			dispCnt <= '0;
		else if (dispEn)
			dispCnt <= curAddr + 1'b1;
		else if (lineStart)
			dispCnt <= '0;
	end

	// Read only the display bank, fill bank stays free for the writer
	always_comb
	begin
		for (int b = 0; b < `NUM_BANKS; b++)
			rdEn[b] = dispEn && (b == int'(lineFlip));
	end

	// Delay side inputs by the RAM latency
	always_ff @(posedge CLK_1MB)
	begin
		fixQ <= fix;
		blankQ <= blank;
		selQ <= lineFlip;
	end

	assign sprPix = rdData[selQ];
	assign fixOpaque = (fixQ.color != '0);

	// Priority: blank, then opaque fix, then sprite
	always_comb
	begin
		if (blankQ)
			paNext = '0;
		else if (fixOpaque)
			paNext = {{(`PA_W - `FIXPAL_W - `COL_W){1'b0}}, fixQ.palette, fixQ.color};
		else
			paNext = {sprPix.palette, sprPix.color};
	end

	// Stage 2, registered palette address
	always_ff @(posedge CLK_1MB)
	begin
		pa <= paNext;
		if (!rstN)
		begin
			validQ <= 1'b0;
			paValid <= 1'b0;
		end
		else
		begin
			validQ <= dispEn;
			paValid <= validQ;	// Two cycles after dispEn
		end
	end

endmodule

// ==== spriteWriter.sv ====
`timescale 1ns/1ns
`include "videoBackend_macros.svh"

module spriteWriter (
	input logic CLK_1MB,
	input logic rstN,
	input videoBackendPkg::spanCmd_t span,	// Position, palette and direction
	input logic [`COL_W-1:0] sprColor,	// One pixel per cycle after load
	input logic sprValid,
	input logic lineFlip,	// Display bank index, fill is the other
	output videoBackendPkg::lbWrite_t lbWr [`NUM_BANKS]
);
	import videoBackendPkg::*;

	wrState_t state;
	logic [`LB_AW-1:0] wrAddr;	// LB address counter
	logic [`PAL_W-1:0] palQ;	// Latched span palette
	logic hFlipQ;	// Latched direction
	logic flipQ;
	logic flipEdge;
	logic fillBank;
	logic pixWe;
	sprPix_t pixData;

	// Buffer swap ends any span in progress
	assign flipEdge = lineFlip ^ flipQ;
	assign fillBank = ~lineFlip;

	always_ff @(posedge CLK_1MB)
	begin
		if (!rstN)
		begin
			state <= WR_IDLE;
			flipQ <= 1'b0;
		end
		else
		begin
			flipQ <= lineFlip;
			case (state)
				WR_IDLE:
					if (span.load)
						state <= WR_SPAN;
				WR_SPAN:
					if (flipEdge && !span.load)
						state <= WR_IDLE;	// New load keeps it running
				default:
					state <= WR_IDLE;
			endcase
		end
	end

	// Position and palette latch, then step once per pixel
	always_ff @(posedge CLK_1MB)
	begin
		if (span.load)
		begin
			wrAddr <= span.xPos;
			palQ <= span.palette;
			hFlipQ <= span.hFlip;
		end
		else if (sprValid && state == WR_SPAN)
		begin
			if (hFlipQ)
				wrAddr <= wrAddr - 1'b1;	// Wraps 0 -> 255
			else
				wrAddr <= wrAddr + 1'b1;	// Wraps 255 -> 0
		end
	end

	// Color 0 still steps the counter but leaves the entry alone
	assign pixWe = (state == WR_SPAN) && sprValid && (sprColor != '0);
	assign pixData.palette = palQ;
	assign pixData.color = sprColor;

	// Same address and data to all banks, only fill bank gets we
	always_comb
	begin
		for (int b = 0; b < `NUM_BANKS; b++)
		begin
			lbWr[b].we = pixWe && (b == int'(fillBank));
			lbWr[b].addr = wrAddr;
			lbWr[b].data = pixData;
		end
	end

endmodule

// ==== tb.f ====
+incdir+.
videoBackendPkg.sv
spriteWriter.sv
lineBufBank.sv
pixelMixer.sv
watchdog.sv
videoBackend.sv
tb_videoBackend.sv

// ==== tb_videoBackend.sv ====
`timescale 1ns/1ns
`include "videoBackend_macros.svh"

module tb_videoBackend;
	import videoBackendPkg::*;

	// One display line per entry
	typedef struct packed {
		int xPos;
		int palette;
		logic hFlip;
		int len;	// Span length in pixels
		int blankLo;	// First blanked pixel
		int blankHi;	// One past the last blanked pixel
		logic fixOpaque;
	} lineTest_t;

	logic CLK_1MB;
	logic rstN;
	spanCmd_t span;
	logic [`COL_W-1:0] sprColor;
	logic sprValid;
	logic lineFlip;
	logic dispEn;
	logic lineStart;
	fixPix_t fix;
	logic blank;
	logic [`PA_W-1:0] pa;
	logic paValid;
	wbReq_t wbReq;
	wbRsp_t wbRsp;
	logic sysRstN;

	int cycles = 0;
	int errors = 0;
	int passCount = 0;
	int failCount = 0;
	int lowCycles = 0;	// Cycles seen with sysRstN low
	logic [31:0] lfsr = 32'had5b;
	logic flipReg = 1'b0;
	string curName = "reset";
	string testName [$];
	lineTest_t lineTable [$];
	logic [`PA_W-1:0] expPa [$];	// Pending pixels in display order
	int expDue [$];	// Cycle where paValid must show
	sprPix_t lineModel [`NUM_BANKS][`LB_DEPTH] = '{default: '0};	// Banks start cleared

	videoBackend DUT (
		.CLK_1MB(CLK_1MB),
		.rstN(rstN),
		.span(span),
		.sprColor(sprColor),
		.sprValid(sprValid),
		.lineFlip(lineFlip),
		.dispEn(dispEn),
		.lineStart(lineStart),
		.fix(fix),
		.blank(blank),
		.pa(pa),
		.paValid(paValid),
		.wbReq(wbReq),
		.wbRsp(wbRsp),
		.sysRstN(sysRstN)
	);

	initial
	begin
		CLK_1MB = 1'b0;
		forever #20 CLK_1MB = ~CLK_1MB;	// 40 ns period
	end

	always @(posedge CLK_1MB)
		cycles <= cycles + 1;

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] galoisStep(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	task automatic randBits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			v = {v[30:0], lfsr[0]};	// One step per bit
			lfsr = galoisStep(lfsr);
		end
	endtask

	// Blank beats fix and opaque fix beats sprite
	function automatic logic [`PA_W-1:0] mixExpected(input sprPix_t s, input fixPix_t f,
		input logic bl);
		if (bl)
			return '0;
		if (f.color != '0)
			return `PA_W'({f.palette, f.color});	// Upper bits zero
		return {s.palette, s.color};
	endfunction

	task automatic checkPa(input string name, input logic [`PA_W-1:0] expVal,
		input logic [`PA_W-1:0] actVal);
		if (actVal !== expVal)
		begin
			errors++;
			$display("[FAIL] %s: expected pa %h, actual %h", name, expVal, actVal);
		end
	endtask

	task automatic checkWb(input string name, input wbRsp_t expVal, input wbRsp_t actVal);
		if (actVal !== expVal)
		begin
			errors++;
			$display("[FAIL] %s: expected ack %b dat %0d, actual ack %b dat %0d", name,
				expVal.ack, expVal.dat, actVal.ack, actVal.dat);
		end
	endtask

	task automatic checkCount(input string name, input int expVal, input int actVal);
		if (actVal != expVal)
		begin
			errors++;
			$display("[FAIL] %s: expected %0d, actual %0d", name, expVal, actVal);
		end
	endtask

	task automatic reportTest(input string name, input int errStart);
		if (errors == errStart)
		begin
			passCount++;
			$display("test %s: ok", name);
		end
		else
		begin
			failCount++;
			$display("test %s: %0d errors", name, errors - errStart);
		end
	endtask

	// Pixel output side sampled mid-cycle
	always @(negedge CLK_1MB)
	begin
		if (!sysRstN)
			lowCycles++;
		if (paValid)
		begin
			if (expPa.size() == 0)
			begin
				errors++;
				$display("Error in %s: paValid high with no pixel pending", curName);
			end
			else
			begin
				if (cycles != expDue[0])
				begin
					errors++;
					$display("Error in %s: paValid at cycle %0d, due at %0d", curName,
						cycles, expDue[0]);
				end
				checkPa(curName, expPa[0], pa);
				void'(expPa.pop_front());
				void'(expDue.pop_front());
			end
		end
		else if (expDue.size() != 0 && cycles > expDue[0])
		begin
			errors++;
			$display("Error in %s: paValid missing at cycle %0d", curName, expDue[0]);
			void'(expPa.pop_front());	// Drop it so the rest stay aligned
			void'(expDue.pop_front());
		end
	end

	// Classic cycle with the request held until ack
	task automatic wbAccess(input logic we, input logic [`WB_AW-1:0] adr, output wbRsp_t rsp,
		output int stamp);
		wbRsp_t idleRsp;
		idleRsp = '0;
		@(posedge CLK_1MB);
		stamp = cycles;
		wbReq <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: '0};
		repeat (2)
			@(negedge CLK_1MB);	// Ack due the cycle after the request is seen
		rsp = wbRsp;
		@(posedge CLK_1MB);
		wbReq <= '0;
		@(negedge CLK_1MB);
		checkWb("wbAckOneCycle", idleRsp, wbRsp);	// Ack lasts a single cycle
	endtask

	task automatic runWatchdog();
		wbRsp_t rsp;
		wbRsp_t expRsp;
		int kickAt;
		int readAt;
		int errStart;
		int lowStart;
		int delta;
		int pulse;
		curName = "wdKickRead";
		errStart = errors;
		lowStart = lowCycles;
		expRsp = '{ack: 1'b1, dat: '0};	// Writes return zero data
		wbAccess(1'b1, `WB_AW'd0, rsp, kickAt);
		checkWb("wdKick", expRsp, rsp);
		for (int k = 0; k < 3; k++)
		begin
			repeat (300 + 100 * k) @(posedge CLK_1MB);
			for (int j = 0; j < 2; j++)
			begin
				wbAccess(1'b0, `WB_AW'd1, rsp, readAt);
				// Reload lands one cycle after the kick request
				expRsp.dat = `WB_DW'(`WD_LIMIT - (readAt - kickAt - 1));
				checkWb("wdRead", expRsp, rsp);
				repeat (100) @(posedge CLK_1MB);
			end
			expRsp.dat = '0;
			wbAccess(1'b1, `WB_AW'd0, rsp, kickAt);
			checkWb("wdKick", expRsp, rsp);
		end
		checkCount("wdKickRead low cycles", 0, lowCycles - lowStart);
		reportTest(curName, errStart);

		// No more kicks from here
		curName = "wdExpire";
		errStart = errors;
		while (sysRstN)
			@(negedge CLK_1MB);
		delta = cycles - (kickAt + 2);
		if (delta < `WD_LIMIT || delta > `WD_LIMIT + 2)
		begin
			errors++;
			$display("[FAIL] wdExpire: expected reset after %0d..%0d cycles, actual %0d",
				`WD_LIMIT, `WD_LIMIT + 2, delta);
		end
		pulse = 0;
		while (!sysRstN)
		begin
			pulse++;
			@(negedge CLK_1MB);
		end
		checkCount("wdPulse", `WD_PULSE, pulse);
		reportTest(curName, errStart);
	endtask

	task automatic runLine(input int t);
		lineTest_t lt;
		logic fb;
		logic [`LB_AW-1:0] addr;
		logic [`LB_AW-1:0] xa;
		logic [31:0] r;
		logic [31:0] sel;
		sprPix_t entry;
		fixPix_t fx;
		logic bl;
		int errStart;
		lt = lineTable[t];
		curName = testName[t];
		errStart = errors;
		fb = ~flipReg;	// Fill bank
		addr = `LB_AW'(lt.xPos);
		@(posedge CLK_1MB);
		span <= '{load: 1'b1, xPos: `LB_AW'(lt.xPos), palette: `PAL_W'(lt.palette),
			hFlip: lt.hFlip};
		for (int i = 0; i < lt.len; i++)
		begin
			randBits(`COL_W, r);
			@(posedge CLK_1MB);
			span <= '0;
			sprValid <= 1'b1;
			sprColor <= r[`COL_W-1:0];
			if (r[`COL_W-1:0] != '0)	// Color 0 leaves the entry
				lineModel[fb][addr] = '{palette: `PAL_W'(lt.palette), color: r[`COL_W-1:0]};
			addr = lt.hFlip ? addr - `LB_AW'd1 : addr + `LB_AW'd1;
		end
		@(posedge CLK_1MB);
		span <= '0;
		sprValid <= 1'b0;
		sprColor <= '0;
		@(posedge CLK_1MB);
		lineFlip <= fb;	// Filled bank goes on screen
		flipReg = fb;
		for (int x = 0; x < `LB_DEPTH; x++)
		begin
			if (x % 64 == 63)
			begin
				@(posedge CLK_1MB);
				dispEn <= 1'b0;	// Idle gap inside the line
				lineStart <= 1'b0;
			end
			xa = `LB_AW'(x);
			randBits(`FIXPAL_W, r);
			randBits(1, sel);
			fx.palette = r[`FIXPAL_W-1:0];
			randBits(`COL_W, r);
			fx.color = (lt.fixOpaque && sel[0]) ? r[`COL_W-1:0] : '0;
			bl = (x >= lt.blankLo) && (x < lt.blankHi);
			entry = lineModel[fb][xa];
			lineModel[fb][xa] = '0;	// Cleared by the read
			@(posedge CLK_1MB);
			dispEn <= 1'b1;
			lineStart <= (x == 0);
			fix <= fx;
			blank <= bl;
			expPa.push_back(mixExpected(entry, fx, bl));
			expDue.push_back(cycles + 3);	// Two cycles after the sampling edge
		end
		@(posedge CLK_1MB);
		dispEn <= 1'b0;
		lineStart <= 1'b0;
		fix <= '0;
		blank <= 1'b0;
		while (expPa.size() != 0)
			@(negedge CLK_1MB);
		reportTest(curName, errStart);
	endtask

	task automatic addTest(input string name, input int xPos, input int palette,
		input logic hFlip, input int len, input int blankLo, input int blankHi,
		input logic fixOpaque);
		lineTest_t lt;
		lt = '{xPos: xPos, palette: palette, hFlip: hFlip, len: len, blankLo: blankLo,
			blankHi: blankHi, fixOpaque: fixOpaque};
		testName.push_back(name);
		lineTable.push_back(lt);
	endtask

	// Runaway guard starts once the table is loaded at time 0
	initial
	begin
		@(posedge CLK_1MB);
		while (cycles < lineTable.size() * 600 + 3 * `WD_LIMIT)
			@(posedge CLK_1MB);
		$display("Timeout: run stopped after %0d cycles", cycles);
		$display("Testbench failed");
		$finish;
	end

	initial
	begin
		rstN <= 1'b0;
		span <= '0;
		sprColor <= '0;
		sprValid <= 1'b0;
		lineFlip <= 1'b0;
		dispEn <= 1'b0;
		lineStart <= 1'b0;
		fix <= '0;
		blank <= 1'b0;
		wbReq <= '0;
		addTest("spanUp", 16, 'h3a, 1'b0, 64, 0, 0, 1'b0);
		addTest("spanDownWrap", 5, 'hc1, 1'b1, 40, 0, 0, 1'b0);
		addTest("refillClears", 200, 'h57, 1'b0, 90, 0, 0, 1'b0);	// Same bank as spanUp
		addTest("fixOverride", 100, 'h9e, 1'b0, 120, 0, 0, 1'b1);
		addTest("blankWindow", 250, 'h24, 1'b1, 256, 180, 256, 1'b1);
		repeat (16) @(posedge CLK_1MB);
		rstN <= 1'b1;
		repeat (260) @(posedge CLK_1MB);	// Bank clear sweep
		runWatchdog();
		for (int t = 0; t < lineTable.size(); t++)
			runLine(t);
		$display("%0d tests passed, %0d failed, %0d errors", passCount, failCount, errors);
		if (errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

// ==== videoBackend.sv ====
`timescale 1ns/1ns
`include "videoBackend_macros.svh"

module videoBackend (
	input logic CLK_1MB,
	input logic rstN,
	input videoBackendPkg::spanCmd_t span,
	input logic [`COL_W-1:0] sprColor,
	input logic sprValid,
	input logic lineFlip,	// Changes between lines only
	input logic dispEn,
	input logic lineStart,
	input videoBackendPkg::fixPix_t fix,
	input logic blank,
	output logic [`PA_W-1:0] pa,
	output logic paValid,
	input videoBackendPkg::wbReq_t wbReq,
	output videoBackendPkg::wbRsp_t wbRsp,
	output logic sysRstN
);
	import videoBackendPkg::*;

	lbWrite_t lbWr [`NUM_BANKS];	// Per bank write
	logic [`NUM_BANKS-1:0] rdEn;
	logic [`LB_AW-1:0] rdAddr;	// Shared, only one bank reads
	sprPix_t rdData [`NUM_BANKS];

	// Fill side
	spriteWriter uWriter (
		.CLK_1MB(CLK_1MB),
		.rstN(rstN),
		.span(span),
		.sprColor(sprColor),
		.sprValid(sprValid),
		.lineFlip(lineFlip),
		.lbWr(lbWr)
	);

	// Ping-pong line buffers
	for (genvar g = 0; g < `NUM_BANKS; g++)
	begin : genBank
		lineBufBank uBank (
			.CLK_1MB(CLK_1MB),
			.rstN(rstN),
			.wr(lbWr[g]),
			.rdEn(rdEn[g]),
			.rdAddr(rdAddr),
			.rdData(rdData[g])
		);
	end

	// Display side
	pixelMixer uMixer (
		.CLK_1MB(CLK_1MB),
		.rstN(rstN),
		.dispEn(dispEn),
		.lineStart(lineStart),
		.lineFlip(lineFlip),
		.fix(fix),
		.blank(blank),
		.rdEn(rdEn),
		.rdAddr(rdAddr),
		.rdData(rdData),
		.pa(pa),
		.paValid(paValid)
	);

	watchdog uWatchdog (
		.CLK_1MB(CLK_1MB),
		.rstN(rstN),
		.wbReq(wbReq),
		.wbRsp(wbRsp),
		.sysRstN(sysRstN)
	);

endmodule

// ==== videoBackendPkg.sv ====
`include "videoBackend_macros.svh"

package videoBackendPkg;

	// One line buffer entry
	typedef struct packed {
		logic [`PAL_W-1:0] palette;
		logic [`COL_W-1:0] color;
	} sprPix_t;

	// Fix layer pixel, color 0 lets sprites through
	typedef struct packed {
		logic [`FIXPAL_W-1:0] palette;
		logic [`COL_W-1:0] color;
	} fixPix_t;

	// Writer to bank
	typedef struct packed {
		logic we;
		logic [`LB_AW-1:0] addr;
		sprPix_t data;
	} lbWrite_t;

	// Span setup, load is a one cycle strobe
	typedef struct packed {
		logic load;
		logic [`LB_AW-1:0] xPos;	// First pixel position
		logic [`PAL_W-1:0] palette;
		logic hFlip;	// Count down instead of up
	} spanCmd_t;

	// Wishbone classic request and response
	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		logic [`WB_AW-1:0] adr;
		logic [`WB_DW-1:0] dat;
	} wbReq_t;

	typedef struct packed {
		logic ack;
		logic [`WB_DW-1:0] dat;
	} wbRsp_t;

	typedef enum logic {WD_RUN, WD_RESET} wdState_t;
	typedef enum logic {WR_IDLE, WR_SPAN} wrState_t;

endpackage

// ==== videoBackend_macros.svh ====
`ifndef VIDEOBACKEND_MACROS_SVH
`define VIDEOBACKEND_MACROS_SVH

// Line buffer geometry
`define LB_AW 8	// One entry per pixel of a line
`define LB_DEPTH 256
`define NUM_BANKS 2	// Ping-pong pair

// Pixel and palette address fields
`define PAL_W 8	// Sprite palette number
`define COL_W 4	// Color index, 0 is transparent
`define FIXPAL_W 4	// Fix palette number
`define PA_W 12	// Palette RAM address

// Watchdog timing in CLK_1MB cycles
`define WD_LIMIT 2000
`define WD_PULSE 8	// Length of sysRstN low

// Wishbone slave port
`define WB_AW 2
`define WB_DW 16
`endif

// ==== watchdog.sv ====
`timescale 1ns/1ns
`include "videoBackend_macros.svh"

module watchdog (
	input logic CLK_1MB,
	input logic rstN,
	input videoBackendPkg::wbReq_t wbReq,	// CPU side
	output videoBackendPkg::wbRsp_t wbRsp,
	output logic sysRstN	// System reset pulse, active low
);
	import videoBackendPkg::*;

	wdState_t state;
	logic [`WB_DW-1:0] cnt;	// Remaining cycles, or pulse length in WD_RESET
	logic ackQ;
	logic [`WB_DW-1:0] rdDat;
	logic wbHit;
	logic kick;

	// New request seen, ack goes out next cycle for one cycle
	assign wbHit = wbReq.cyc && wbReq.stb && !ackQ;
	assign kick = wbHit && wbReq.we && (wbReq.adr == `WB_AW'd0);

	always_ff @(posedge CLK_1MB)
	begin
		if (!rstN)
			ackQ <= 1'b0;
		else
			ackQ <= wbHit;
		if (wbHit && !wbReq.we && wbReq.adr == `WB_AW'd1)
			rdDat <= cnt;	// Remaining count
		else
			rdDat <= '0;
	end

	assign wbRsp.ack = ackQ;
	assign wbRsp.dat = rdDat;

	always_ff @(posedge CLK_1MB)
	begin
		if (!rstN)
		begin
			state <= WD_RUN;
			cnt <= `WB_DW'(`WD_LIMIT);
		end
		else
		begin
			case (state)
				WD_RUN:
					if (kick)
						cnt <= `WB_DW'(`WD_LIMIT);	// Reload
					else if (cnt == '0)
					begin
						state <= WD_RESET;	// Expired
						cnt <= `WB_DW'(`WD_PULSE - 1);
					end
					else
						cnt <= cnt - 1'b1;
				WD_RESET:
					if (cnt == '0)
					begin
						state <= WD_RUN;	// Count again from the top
						cnt <= `WB_DW'(`WD_LIMIT);
					end
					else
						cnt <= cnt - 1'b1;	// Kicks ignored here
				default:
					state <= WD_RUN;
			endcase
		end
	end

	assign sysRstN = (state != WD_RESET);

endmodule
